// File: bench/bp_golden.txt
# test fetch_pc fetch_ins res_valid res_pc res_target res_taken res_predicted
#   then expected: pred_taken pred_target flush recover_pc (all hex, one row per cycle)
# empty table, every lookup misses
1 00001000 00000063 0 00000000 00000000 0 0 0 00001000 0 00000004
1 00001004 0000006f 0 00000000 00000000 0 0 0 00001004 0 00000004
1 00001010 00000067 0 00000000 00000000 0 0 0 00001010 0 00000004
1 00001100 00000063 0 00000000 00000000 0 0 0 00001100 0 00000004
# install taken at 1100 and not taken at 1208, visible one cycle later
2 00001100 00000063 1 00001100 00001200 1 0 0 00001100 1 00001200
2 00001100 00000063 0 00000000 00000000 0 0 1 00001200 0 00000004
2 00001208 00000063 1 00001208 00001300 0 0 0 00001208 0 0000120c
2 00001208 00000063 0 00000000 00000000 0 0 0 00001300 0 00000004
# counter at 1100 runs up to strong taken, then two not taken steps
3 00001100 00000063 1 00001100 00001200 1 1 1 00001200 0 00001200
3 00001100 00000063 1 00001100 00001200 1 1 1 00001200 0 00001200
3 00001100 00000063 1 00001100 00001200 1 1 1 00001200 0 00001200
3 00001100 00000063 1 00001100 00001200 0 1 1 00001200 1 00001104
3 00001100 00000063 1 00001100 00001200 0 1 1 00001200 1 00001104
3 00001100 00000063 0 00000000 00000000 0 0 0 00001200 0 00000004
# flush and recovery at 3010, fetch side idles on a missing alu op
4 00002000 00000013 1 00003010 00003400 1 0 0 00002000 1 00003400
4 00002000 00000013 1 00003010 00003400 0 1 0 00002000 1 00003014
4 00002000 00000013 1 00003010 00003400 1 1 0 00002000 0 00003400
4 00002000 00000013 0 00003010 00003400 1 0 0 00002000 0 00003400
4 00002000 00000013 0 00003010 00003400 0 1 0 00002000 0 00003014
# non-branch opcodes on hitting pcs
5 00003010 00000013 0 00000000 00000000 0 0 0 00003400 0 00000004
5 00003010 0000006f 0 00000000 00000000 0 0 1 00003400 0 00000004
5 00003010 00000067 0 00000000 00000000 0 0 1 00003400 0 00000004
5 00001100 00000033 0 00000000 00000000 0 0 0 00001200 0 00000004
5 00001208 00000003 0 00000000 00000000 0 0 0 00001300 0 00000004
# 1100 and 5100 share index 0 and evict each other
6 00001100 00000063 1 00005100 00005800 1 0 0 00001200 1 00005800
6 00001100 00000063 0 00000000 00000000 0 0 0 00001100 0 00000004
6 00005100 00000063 0 00000000 00000000 0 0 1 00005800 0 00000004
6 00005100 00000063 1 00001100 00001200 1 0 1 00005800 1 00001200
6 00005100 00000063 0 00000000 00000000 0 0 0 00005100 0 00000004
6 00001100 00000063 0 00000000 00000000 0 0 1 00001200 0 00000004
6 00003010 00000063 0 00000000 00000000 0 0 1 00003400 0 00000004

// File: bench/bp_tb.sv
// branch predictor testbench that replays golden rows and checks predictions and flush
`timescale 1ns/1ps
`include "bp_defs.svh"

module bp_tb;

    localparam int    CLK_PERIOD    = 100;
    localparam int    RST_CYCLES    = 4;
    localparam int    DRIVE_DLY     = 5;   // inputs change just after the edge
    localparam int    MARGIN_CYCLES = 10;
    localparam string GOLDEN_PATH   = "bench/bp_golden.txt";

    logic                clk = 1'b0;
    logic                rst_n;
    logic [`BP_XLEN-1:0] fetch_pc;
    logic [`BP_XLEN-1:0] fetch_ins;
    logic                res_valid;
    logic [`BP_XLEN-1:0] res_pc;
    logic [`BP_XLEN-1:0] res_target;
    logic                res_taken;
    logic                res_predicted;
    logic                pred_taken;
    logic [`BP_XLEN-1:0] pred_target;
    logic                flush;
    logic [`BP_XLEN-1:0] recover_pc;

    // golden rows with one entry per cycle
    int                  row_id  [$];
    logic [`BP_XLEN-1:0] row_fpc [$];
    logic [`BP_XLEN-1:0] row_fins[$];
    logic                row_rv  [$];
    logic [`BP_XLEN-1:0] row_rpc [$];
    logic [`BP_XLEN-1:0] row_rtgt[$];
    logic                row_rtk [$];
    logic                row_rprd[$];
    logic                row_etk [$];
    logic [`BP_XLEN-1:0] row_etgt[$];
    logic                row_efl [$];
    logic [`BP_XLEN-1:0] row_erec[$];

    bit rows_loaded = 1'b0;  // releases the watchdog
    int test_errs   = 0;     // errors in the test id now running
    int total_errs  = 0;
    int pass_tests  = 0;
    int fail_tests  = 0;
    int bad_lines   = 0;

    always #(CLK_PERIOD/2) clk = ~clk;

    branch_predictor branch_predictor_inst (
        .clk           (clk),
        .rst_n         (rst_n),
        .fetch_pc      (fetch_pc),
        .fetch_ins     (fetch_ins),
        .res_valid     (res_valid),
        .res_pc        (res_pc),
        .res_target    (res_target),
        .res_taken     (res_taken),
        .res_predicted (res_predicted),
        .pred_taken    (pred_taken),
        .pred_target   (pred_target),
        .flush         (flush),
        .recover_pc    (recover_pc)
    );

    // reads every data row while '#' lines fail the scan and drop out
    task automatic load_golden(output bit ok);
        int                  fd;
        int                  n;
        string               line;
        int                  id;
        logic [`BP_XLEN-1:0] fpc;
        logic [`BP_XLEN-1:0] fins;
        logic [`BP_XLEN-1:0] rpc;
        logic [`BP_XLEN-1:0] rtgt;
        logic [`BP_XLEN-1:0] etgt;
        logic [`BP_XLEN-1:0] erec;
        logic                rv;
        logic                rtk;
        logic                rprd;
        logic                etk;
        logic                efl;
        ok = 1'b0;
        fd = $fopen(GOLDEN_PATH, "r");
        if (fd != 0) begin
            while (!$feof(fd)) begin
                line = "";
                void'($fgets(line, fd));
                n = $sscanf(line, "%d %h %h %h %h %h %h %h %h %h %h %h", id, fpc, fins,
                            rv, rpc, rtgt, rtk, rprd, etk, etgt, efl, erec);
                if (n == 12) begin
                    row_id.push_back(id);
                    row_fpc.push_back(fpc);
                    row_fins.push_back(fins);
                    row_rv.push_back(rv);
                    row_rpc.push_back(rpc);
                    row_rtgt.push_back(rtgt);
                    row_rtk.push_back(rtk);
                    row_rprd.push_back(rprd);
                    row_etk.push_back(etk);
                    row_etgt.push_back(etgt);
                    row_efl.push_back(efl);
                    row_erec.push_back(erec);
                end else if (n > 0) begin
                    bad_lines++; // row with missing fields
                    $display("golden file line is incomplete and was skipped: %s", line);
                end
            end
            $fclose(fd);
            ok = (row_id.size() > 0);
        end
    endtask

    task automatic drive_row(input int r);
        fetch_pc      = row_fpc[r];
        fetch_ins     = row_fins[r];
        res_valid     = row_rv[r];
        res_pc        = row_rpc[r];
        res_target    = row_rtgt[r];
        res_taken     = row_rtk[r];
        res_predicted = row_rprd[r];
    endtask

    // outputs are combinational and settle well before this point
    task automatic check_row(input int r);
        assert (pred_taken === row_etk[r]) else begin
            $display("Error: %0t ns test %0d row %0d pred_taken is %b, expected %b",
                     $time, row_id[r], r, pred_taken, row_etk[r]);
            test_errs++;
        end
        assert (pred_target === row_etgt[r]) else begin
            $display("Error: %0t ns test %0d row %0d pred_target is %h, expected %h",
                     $time, row_id[r], r, pred_target, row_etgt[r]);
            test_errs++;
        end
        assert (flush === row_efl[r]) else begin
            $display("Error: %0t ns test %0d row %0d flush is %b, expected %b",
                     $time, row_id[r], r, flush, row_efl[r]);
            test_errs++;
        end
        assert (recover_pc === row_erec[r]) else begin
            $display("Error: %0t ns test %0d row %0d recover_pc is %h, expected %h",
                     $time, row_id[r], r, recover_pc, row_erec[r]);
            test_errs++;
        end
    endtask

    // one line per finished test id
    task automatic close_test(input int id, input int rows);
        if (test_errs == 0) begin
            pass_tests++;
            $display("test %0d ok, %0d rows", id, rows);
        end else begin
            fail_tests++;
            $display("test %0d FAIL, %0d errors over %0d rows", id, test_errs, rows);
        end
        total_errs += test_errs;
        test_errs = 0;
    endtask

    initial begin
        bit loaded;
        int r;
        int rows_in_test;
        rst_n         = 1'b0;  // reset from time zero
        fetch_pc      = '0;
        fetch_ins     = '0;
        res_valid     = 1'b0;
        res_pc        = '0;
        res_target    = '0;
        res_taken     = 1'b0;
        res_predicted = 1'b0;
        rows_in_test  = 0;
        load_golden(loaded);
        if (!loaded) begin
            $display("golden file %s is missing or holds no rows", GOLDEN_PATH);
            $display("Some tests failed");
            $finish;
        end else begin
            rows_loaded = 1'b1;
            repeat (RST_CYCLES) @(posedge clk);
            #(DRIVE_DLY);
            rst_n = 1'b1;
            for (r = 0; r < row_id.size(); r++) begin
                @(posedge clk);
                #(DRIVE_DLY);
                drive_row(r);
                #(CLK_PERIOD - 2*DRIVE_DLY); // sample just ahead of the next edge
                check_row(r);
                rows_in_test++;
                if (r == row_id.size() - 1 || row_id[r+1] != row_id[r]) begin
                    close_test(row_id[r], rows_in_test);
                    rows_in_test = 0;
                end
            end
            $display("summary: %0d passed, %0d failed, %0d errors, %0d bad golden lines",
                     pass_tests, fail_tests, total_errs, bad_lines);
            if (fail_tests == 0 && bad_lines == 0) begin
                $display("All tests passed");
            end else begin
                $display("Some tests failed");
            end
            $finish;
        end
    end

    // run length follows the row count
    initial begin
        wait (rows_loaded);
        #((row_id.size() + RST_CYCLES + MARGIN_CYCLES) * CLK_PERIOD);
        $display("watchdog expired, the run did not finish in the expected time");
        $display("Some tests failed");
        $finish;
    end

endmodule

// File: include/bp_defs.svh
// branch predictor sizing and risc-v opcode constants
`ifndef BP_DEFS_SVH
`define BP_DEFS_SVH

// address and instruction width
`define BP_XLEN 32

// btb depth, keep a power of two
`define BP_ENTRIES 16

// index bits taken from the pc
`define BP_IDX_W $clog2(`BP_ENTRIES)

// pc[1:0] never takes part in index or tag
`define BP_IDX_LSB 2

// upper pc bits left over after index and byte offset
`define BP_TAG_W (`BP_XLEN - `BP_IDX_W - `BP_IDX_LSB)

// opcode field position in the instruction word
`define BP_OPC_W 7

// rv32i control transfer opcodes
`define OPC_BRANCH 7'b1100011 // beq, bne, blt, bge, bltu, bgeu
`define OPC_JAL 7'b1101111    // direct jump
`define OPC_JALR 7'b1100111   // register indirect jump

`endif

// File: sim.f
+incdir+include
src/bp_pkg.sv
src/btb_table.sv
src/fetch_predict.sv
src/resolve_update.sv
src/branch_predictor.sv
bench/bp_tb.sv

// File: src/bp_pkg.sv
// branch predictor package holding the saturating counter type
package bp_pkg;

    // two-bit saturating counter per btb entry
    // msb is the taken prediction
    // values ordered so +1 moves toward taken
    typedef enum logic [1:0] {
        CTR_SNT = 2'b00, // strong not taken
        CTR_WNT = 2'b01, // weak not taken
        CTR_WT  = 2'b10, // weak taken
        CTR_ST  = 2'b11  // strong taken
    } ctr_e;

endpackage

// File: src/branch_predictor.sv
// branch predictor top joining fetch lookup, btb and resolve update
`timescale 1ns/1ps
`include "bp_defs.svh"

module branch_predictor (
    input  logic                clk,
    input  logic                rst_n,
    // fetch side
    input  logic [`BP_XLEN-1:0] fetch_pc,
    input  logic [`BP_XLEN-1:0] fetch_ins,
    // resolve side from execute
    input  logic                res_valid,
    input  logic [`BP_XLEN-1:0] res_pc,
    input  logic [`BP_XLEN-1:0] res_target,
    input  logic                res_taken,
    input  logic                res_predicted,
    // prediction out, same cycle as fetch_pc
    output logic                pred_taken,
    output logic [`BP_XLEN-1:0] pred_target,
    // recovery out, same cycle as resolve
    output logic                flush,
    output logic [`BP_XLEN-1:0] recover_pc
);

    // fetch port
    logic [`BP_XLEN-1:0] fetch_lookup_pc;
    logic                fetch_hit;
    logic [`BP_XLEN-1:0] fetch_target;
    bp_pkg::ctr_e        fetch_state;

    // resolve port
    logic [`BP_XLEN-1:0] res_lookup_pc; // shared by read and write
    logic                res_hit;
    bp_pkg::ctr_e        res_state;
    logic                wr_en;
    logic [`BP_XLEN-1:0] wr_target;
    bp_pkg::ctr_e        wr_state;

    fetch_predict fetch_predict_inst (
        .fetch_pc    (fetch_pc),
        .fetch_ins   (fetch_ins),
        .hit         (fetch_hit),
        .target      (fetch_target),
        .state       (fetch_state),
        .lookup_pc   (fetch_lookup_pc),
        .pred_taken  (pred_taken),
        .pred_target (pred_target)
    );

    btb_table btb_table_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .rd_pc     (fetch_lookup_pc),
        .res_rd_pc (res_lookup_pc),
        .wr_en     (wr_en),
        .wr_pc     (res_lookup_pc),  // write lands where resolve read
        .wr_target (wr_target),
        .wr_state  (wr_state),
        .rd_hit    (fetch_hit),
        .rd_target (fetch_target),
        .rd_state  (fetch_state),
        .res_hit   (res_hit),
        .res_state (res_state)
    );

    resolve_update resolve_update_inst (
        .res_valid     (res_valid),
        .res_pc        (res_pc),
        .res_target    (res_target),
        .res_taken     (res_taken),
        .res_predicted (res_predicted),
        .hit           (res_hit),
        .cur_state     (res_state),
        .lookup_pc     (res_lookup_pc),
        .wr_en         (wr_en),
        .wr_target     (wr_target),
        .wr_state      (wr_state),
        .flush         (flush),
        .recover_pc    (recover_pc)
    );

endmodule

// File: src/btb_table.sv
// direct-mapped branch target buffer with two read ports and one write port
`timescale 1ns/1ps
`include "bp_defs.svh"

module btb_table (
    input  logic                clk,
    input  logic                rst_n,
    // fetch side read
    input  logic [`BP_XLEN-1:0] rd_pc,      // next pc from fetch
    // resolve side read
    input  logic [`BP_XLEN-1:0] res_rd_pc,  // branch pc from execute
    // single write port replacing the whole entry
    input  logic                wr_en,
    input  logic [`BP_XLEN-1:0] wr_pc,      // address that picks index and tag
    input  logic [`BP_XLEN-1:0] wr_target,
    input  bp_pkg::ctr_e        wr_state,
    // fetch side results
    output logic                rd_hit,
    output logic [`BP_XLEN-1:0] rd_target,
    output bp_pkg::ctr_e        rd_state,
    // resolve side results
    output logic                res_hit,
    output bp_pkg::ctr_e        res_state
);

    // entry storage
    logic [`BP_ENTRIES-1:0] valid_q;
    logic [`BP_TAG_W-1:0]   tag_q    [`BP_ENTRIES];
    logic [`BP_XLEN-1:0]    target_q [`BP_ENTRIES];
    bp_pkg::ctr_e           state_q  [`BP_ENTRIES];

    // address split per port
    logic [`BP_IDX_W-1:0] rd_idx;
    logic [`BP_TAG_W-1:0] rd_tag;
    logic [`BP_IDX_W-1:0] res_idx;
    logic [`BP_TAG_W-1:0] res_tag;
    logic [`BP_IDX_W-1:0] wr_idx;
    logic [`BP_TAG_W-1:0] wr_tag;

    // pc[1:0] dropped, next bits index, rest is tag
    assign rd_idx  = rd_pc[`BP_IDX_W+`BP_IDX_LSB-1:`BP_IDX_LSB];
    assign rd_tag  = rd_pc[`BP_XLEN-1:`BP_IDX_W+`BP_IDX_LSB];

    assign res_idx = res_rd_pc[`BP_IDX_W+`BP_IDX_LSB-1:`BP_IDX_LSB];
    assign res_tag = res_rd_pc[`BP_XLEN-1:`BP_IDX_W+`BP_IDX_LSB];

    assign wr_idx  = wr_pc[`BP_IDX_W+`BP_IDX_LSB-1:`BP_IDX_LSB];
    assign wr_tag  = wr_pc[`BP_XLEN-1:`BP_IDX_W+`BP_IDX_LSB];

    // fetch read port
    // combinational and sees contents from before this cycle's write
    always_comb begin
        rd_hit    = valid_q[rd_idx] && (tag_q[rd_idx] == rd_tag);
        rd_target = target_q[rd_idx]; // gated by hit in fetch stage
        rd_state  = state_q[rd_idx];
    end

    // resolve read port
    // gives current counter for the update step
    always_comb begin
        res_hit   = valid_q[res_idx] && (tag_q[res_idx] == res_tag);
        res_state = state_q[res_idx];
    end

    // valid bits with async clear
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_q <= '0; // every lookup misses after reset
        end else if (wr_en) begin
            valid_q[wr_idx] <= 1'b1;
        end
    end

    // entry payload
    // tag, target and counter rewritten together
    always_ff @(posedge clk) begin
        if (wr_en) begin
            tag_q[wr_idx]    <= wr_tag;    // may evict an aliasing pc
            target_q[wr_idx] <= wr_target;
            state_q[wr_idx]  <= wr_state;  // new or stepped counter
        end
    end

endmodule

// File: src/fetch_predict.sv
// fetch stage predictor, opcode classify and target select
`timescale 1ns/1ps
`include "bp_defs.svh"

module fetch_predict (
    input  logic [`BP_XLEN-1:0] fetch_pc,    // next pc
    input  logic [`BP_XLEN-1:0] fetch_ins,   // instruction at fetch_pc
    input  logic                hit,         // btb fetch hit
    input  logic [`BP_XLEN-1:0] target,      // stored target
    input  bp_pkg::ctr_e        state,       // stored counter
    output logic [`BP_XLEN-1:0] lookup_pc,   // to btb fetch port
    output logic                pred_taken,
    output logic [`BP_XLEN-1:0] pred_target
);

    logic [`BP_OPC_W-1:0] opcode;
    logic                 is_branch;
    logic                 is_jal;
    logic                 is_jalr;
    logic                 b_or_j;   // any control transfer

    // btb indexed with the fetch pc itself
    assign lookup_pc = fetch_pc;

    // only the opcode field matters here
    assign opcode = fetch_ins[`BP_OPC_W-1:0];

    // opcode decode
    always_comb begin
        is_branch = (opcode == `OPC_BRANCH); // b-type
        is_jal    = (opcode == `OPC_JAL);
        is_jalr   = (opcode == `OPC_JALR);
        b_or_j    = is_branch || is_jal || is_jalr;
    end

    // direction
    // counter msb, only for a hit on a branch or jump
    always_comb begin
        if (hit && b_or_j) begin
            pred_taken = state[1];
        end else begin
            pred_taken = 1'b0; // miss or plain alu/load/store op
        end
    end

    // target
    // stored target on any hit even if opcode is not a branch
    always_comb begin
        if (hit) begin
            pred_target = target;
        end else begin
            pred_target = fetch_pc; // nothing known, echo pc back
        end
    end

endmodule

// File: src/resolve_update.sv
// resolve stage, counter update, btb write and misprediction recovery
`timescale 1ns/1ps
`include "bp_defs.svh"

module resolve_update (
    input  logic                res_valid,      // execute resolved a branch
    input  logic [`BP_XLEN-1:0] res_pc,         // pc of that branch
    input  logic [`BP_XLEN-1:0] res_target,     // computed target
    input  logic                res_taken,      // actual outcome
    input  logic                res_predicted,  // what fetch predicted
    input  logic                hit,            // btb resolve hit
    input  bp_pkg::ctr_e        cur_state,      // counter now stored
    output logic [`BP_XLEN-1:0] lookup_pc,      // resolve read and write address
    output logic                wr_en,
    output logic [`BP_XLEN-1:0] wr_target,
    output bp_pkg::ctr_e        wr_state,
    output logic                flush,
    output logic [`BP_XLEN-1:0] recover_pc
);

    bp_pkg::ctr_e step_state; // counter after one saturating step

    // same address drives the read port and the write port
    assign lookup_pc = res_pc;

    // every resolved branch writes its entry
    assign wr_en     = res_valid;
    assign wr_target = res_target; // refreshed on each update

    // saturating step
    always_comb begin
        step_state = cur_state;
        if (res_taken) begin
            case (cur_state)
                bp_pkg::CTR_SNT: step_state = bp_pkg::CTR_WNT;
                bp_pkg::CTR_WNT: step_state = bp_pkg::CTR_WT;
                bp_pkg::CTR_WT:  step_state = bp_pkg::CTR_ST;
                bp_pkg::CTR_ST:  step_state = bp_pkg::CTR_ST;  // pinned at top
                default:         step_state = bp_pkg::CTR_WT;
            endcase
        end else begin
            case (cur_state)
                bp_pkg::CTR_SNT: step_state = bp_pkg::CTR_SNT; // pinned at bottom
                bp_pkg::CTR_WNT: step_state = bp_pkg::CTR_SNT;
                bp_pkg::CTR_WT:  step_state = bp_pkg::CTR_WNT;
                bp_pkg::CTR_ST:  step_state = bp_pkg::CTR_WT;
                default:         step_state = bp_pkg::CTR_WNT;
            endcase
        end
    end

    // install or update select
    always_comb begin
        if (hit) begin
            wr_state = step_state;
        end else if (res_taken) begin
            wr_state = bp_pkg::CTR_WT;  // fresh entry, lean taken
        end else begin
            wr_state = bp_pkg::CTR_WNT; // fresh entry, lean not taken
        end
    end

    // misprediction when direction disagrees
    assign flush = res_valid && (res_taken != res_predicted);

    // where fetch must restart
    always_comb begin
        if (res_taken) begin
            recover_pc = res_target;
        end else begin
            recover_pc = res_pc + `BP_XLEN'd4; // fall through
        end
    end

endmodule
